/* source/br_pkg.sv */
// Branch tracking definitions for the rename stage.
// Mask depth, resolve state codes, resolve broadcast struct
// and the checkpointed free-list / store-queue pointers.
package br_pkg;

	localparam int BR_DEPTH = 4; // Outstanding branches, one mask bit each.

	// Widths of the pointers saved with a checkpoint.
	localparam int CKPT_FL_W = 5; // Free-list head.
	localparam int CKPT_SQ_W = 3; // Store-queue tail.

	typedef logic [BR_DEPTH-1:0] br_mask_t; // One bit per live branch.

	typedef logic [1:0] br_state_t;

	// Resolve outcome, broadcast for one cycle.
	localparam br_state_t BR_ST_NONE    = 2'd0; // Nothing resolves.
	localparam br_state_t BR_ST_CORRECT = 2'd1; // Prediction held.
	localparam br_state_t BR_ST_WRONG   = 2'd2; // Mispredict, recover.

	// Resolve broadcast from the back end.
	typedef struct packed {
		br_state_t state;    // Outcome code.
		br_mask_t  tag;      // One-hot tag of the resolving branch.
		br_mask_t  dep_mask; // Mask the branch saw at dispatch.
	} br_res_t;

	// Pointers that travel with a checkpoint.
	typedef struct packed {
		logic [CKPT_FL_W-1:0] fl_head; // Free-list head.
		logic [CKPT_SQ_W-1:0] sq_tail; // Store-queue tail.
	} ckpt_ptr_t;

endpackage

/* source/rename_pkg.sv */
// Register rename definitions.
// Table sizes, map entry and map table types, CDB broadcast,
// dispatch request/response structs and the CDB ready merge.
package rename_pkg;

	localparam int ARCH_REGS  = 8; // Architectural registers.
	localparam int ARCH_IDX_W = 3;
	localparam int PRF_TAG_W  = 5; // Physical tag width.
	localparam int FL_PTR_W   = br_pkg::CKPT_FL_W; // Same as the saved head.
	localparam int SQ_PTR_W   = br_pkg::CKPT_SQ_W; // Same as the saved tail.

	typedef logic [ARCH_IDX_W-1:0] arch_idx_t;
	typedef logic [PRF_TAG_W-1:0]  prf_tag_t;

	typedef struct packed {
		prf_tag_t tag; // Physical register.
		logic     rdy; // Value already written back.
	} map_ent_t;

	typedef map_ent_t [ARCH_REGS-1:0] map_tbl_t; // Indexed by arch reg.

	typedef struct packed {
		logic     valid;
		prf_tag_t tag; // Tag completing this cycle.
	} cdb_t;

	// One instruction offered to rename.
	typedef struct packed {
		logic              is_br;    // Branch, takes a checkpoint.
		logic              has_dest; // Writes a register.
		arch_idx_t         dest;
		arch_idx_t         src1;
		arch_idx_t         src2;
		prf_tag_t          new_tag;  // From the free list.
		br_pkg::ckpt_ptr_t ptr;      // Saved if this is a branch.
	} disp_req_t;

	// Rename result, same cycle as the request.
	typedef struct packed {
		map_ent_t         src1;
		map_ent_t         src2;
		prf_tag_t         old_tag; // Freed when this insn retires.
		br_pkg::br_mask_t br_mask; // Branches this insn depends on.
		br_pkg::br_mask_t br_new;  // Own one-hot for a branch.
	} disp_rsp_t;

	// Sets the ready bit of every entry whose tag is on the CDB.
	function automatic map_tbl_t cdb_merge(map_tbl_t tbl, cdb_t cdb);
		map_tbl_t res;
		res = tbl;
		for (int i = 0; i < ARCH_REGS; i++) begin
			if (cdb.valid && (tbl[i].tag == cdb.tag)) begin
				res[i].rdy = 1'b1;
			end
		end
		return res;
	endfunction

endpackage

/* source/br_mask_ctrl.sv */
// Branch mask controller.
// Holds the current branch mask, picks the lowest free bit for a
// new branch, flags full, and applies correct/wrong resolves.
module br_mask_ctrl (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              br_alloc_i,  // Branch accepted this cycle.
	input  br_pkg::br_res_t   resolve_i,   // Resolve broadcast.
	output br_pkg::br_mask_t  br_mask_o,   // Mask seen by this dispatch.
	output br_pkg::br_mask_t  br_new_o,    // Bit a new branch would take.
	output logic              full_o       // No free bit left.
);

	br_pkg::br_mask_t mask_q;   // Live branches.
	br_pkg::br_mask_t mask_clr; // After a correct resolve.
	br_pkg::br_mask_t mask_nxt;
	logic             res_correct;
	logic             res_wrong;

	assign res_correct = (resolve_i.state == br_pkg::BR_ST_CORRECT);
	assign res_wrong   = (resolve_i.state == br_pkg::BR_ST_WRONG);

	// A correct resolve frees its bit in the same cycle,
	// so a dispatch here may reuse it.
	always_comb begin
		mask_clr = mask_q;
		if (res_correct) begin
			mask_clr = mask_q & ~resolve_i.tag; // Drop the resolved branch.
		end
	end

	// Lowest zero bit: adding one ripples through the low ones.
	// Result is zero when every bit is set.
	assign br_new_o  = ~mask_clr & (mask_clr + br_pkg::br_mask_t'(1));
	assign full_o    = &mask_clr;
	assign br_mask_o = mask_clr;

	always_comb begin
		mask_nxt = mask_clr;
		if (res_wrong) begin
			// Rewind to what the bad branch depended on.
			// Younger branches vanish with it.
			mask_nxt = resolve_i.dep_mask;
		end else if (br_alloc_i) begin
			mask_nxt = mask_clr | br_new_o; // Claim the free bit.
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			mask_q <= '0; // No branch in flight.
		end else begin
			mask_q <= mask_nxt;
		end
	end

endmodule

/* source/br_stack_ent.sv */
// One branch checkpoint slot.
// Saves the map table snapshot and the free-list/store-queue
// pointers, and keeps the snapshot's ready bits current from the CDB.
module br_stack_ent (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                save_i, // Branch allocated into this slot.
	input  rename_pkg::cdb_t    cdb_i,
	input  rename_pkg::map_tbl_t map_i, // Live map before this edge.
	input  br_pkg::ckpt_ptr_t   ptr_i,
	output rename_pkg::map_tbl_t map_o, // Saved map for recovery.
	output br_pkg::ckpt_ptr_t   ptr_o
);

	rename_pkg::map_tbl_t map_q;
	rename_pkg::map_tbl_t map_src; // Live or held snapshot.
	br_pkg::ckpt_ptr_t    ptr_q;

	// A save takes the live map, otherwise keep our own copy.
	assign map_src = save_i ? map_i : map_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			map_q <= '0;
			ptr_q <= '0;
		end else begin
			// Results broadcast while the branch is pending
			// must read ready once we roll back.
			map_q <= rename_pkg::cdb_merge(map_src, cdb_i);
			if (save_i) begin
				ptr_q <= ptr_i; // Pointers never change after capture.
			end
		end
	end

	assign map_o = map_q;
	assign ptr_o = ptr_q;

endmodule

/* source/branch_stack.sv */
// Branch stack.
// Mask controller, one checkpoint slot per mask bit,
// and the recovery mux that picks the mispredicted branch's slot.
module branch_stack (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 br_alloc_i, // Branch dispatched.
	input  br_pkg::br_res_t      resolve_i,
	input  rename_pkg::cdb_t     cdb_i,
	input  rename_pkg::map_tbl_t map_i,      // Live map to snapshot.
	input  br_pkg::ckpt_ptr_t    ptr_i,      // Pointers to snapshot.
	output br_pkg::br_mask_t     br_mask_o,
	output br_pkg::br_mask_t     br_new_o,
	output logic                 full_o,
	output logic                 rc_valid_o, // Recovery this cycle.
	output rename_pkg::map_tbl_t rc_map_o,
	output br_pkg::ckpt_ptr_t    rc_ptr_o
);

	rename_pkg::map_tbl_t ent_map [br_pkg::BR_DEPTH];
	br_pkg::ckpt_ptr_t    ent_ptr [br_pkg::BR_DEPTH];
	br_pkg::br_mask_t     save;     // Per-slot save strobe.

	br_mask_ctrl u_mask_ctrl (
		.clk        (clk),
		.rst_i      (rst_i),
		.br_alloc_i (br_alloc_i),
		.resolve_i  (resolve_i),
		.br_mask_o  (br_mask_o),
		.br_new_o   (br_new_o),
		.full_o     (full_o)
	);

	assign save = br_alloc_i ? br_new_o : '0; // Slot i belongs to mask bit i.

	for (genvar i = 0; i < br_pkg::BR_DEPTH; i++) begin : g_ent
		br_stack_ent u_ent (
			.clk    (clk),
			.rst_i  (rst_i),
			.save_i (save[i]),
			.cdb_i  (cdb_i),
			.map_i  (map_i),
			.ptr_i  (ptr_i),
			.map_o  (ent_map[i]),
			.ptr_o  (ent_ptr[i])
		);
	end

	assign rc_valid_o = (resolve_i.state == br_pkg::BR_ST_WRONG);

	// Recovery mux.
	// Tag is one-hot so at most one slot matches.
	always_comb begin
		rc_map_o = '0;
		rc_ptr_o = '0;
		if (rc_valid_o) begin
			for (int i = 0; i < br_pkg::BR_DEPTH; i++) begin
				if (resolve_i.tag[i]) begin
					rc_map_o = ent_map[i];
					rc_ptr_o = ent_ptr[i];
				end
			end
		end
	end

endmodule

/* source/map_table.sv */
// Register map table.
// Arch-to-physical lookup with CDB ready bypass, rename write,
// ready tracking and full restore from a checkpoint.
module map_table (
	input  logic                  clk,
	input  logic                  rst_i,
	input  rename_pkg::arch_idx_t src1_i,
	input  rename_pkg::arch_idx_t src2_i,
	input  rename_pkg::arch_idx_t dest_i,
	input  logic                  wr_en_i,       // Rename a destination.
	input  rename_pkg::prf_tag_t  new_tag_i,
	input  rename_pkg::cdb_t      cdb_i,
	input  logic                  restore_i,     // Mispredict recovery.
	input  rename_pkg::map_tbl_t  restore_map_i,
	output rename_pkg::map_ent_t  src1_o,
	output rename_pkg::map_ent_t  src2_o,
	output rename_pkg::prf_tag_t  old_tag_o,     // Previous dest mapping.
	output rename_pkg::map_tbl_t  map_o          // Stored table, for checkpoints.
);

	rename_pkg::map_tbl_t map_q;
	rename_pkg::map_tbl_t map_cdb; // Stored table plus this cycle's CDB.
	rename_pkg::map_tbl_t map_nxt;
	rename_pkg::map_tbl_t map_rst; // Identity mapping, all ready.

	assign map_cdb = rename_pkg::cdb_merge(map_q, cdb_i);

	// Sources see the table before this cycle's write.
	// A tag completing now already reads ready.
	assign src1_o    = map_cdb[src1_i];
	assign src2_o    = map_cdb[src2_i];
	assign old_tag_o = map_q[dest_i].tag;
	assign map_o     = map_q;

	always_comb begin
		for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
			map_rst[i].tag = rename_pkg::prf_tag_t'(i); // Reg i starts in tag i.
			map_rst[i].rdy = 1'b1;
		end
	end

	always_comb begin
		map_nxt = map_cdb;
		if (restore_i) begin
			// Checkpoint wins over any write.
			// It still picks up this edge's CDB.
			map_nxt = rename_pkg::cdb_merge(restore_map_i, cdb_i);
		end else if (wr_en_i) begin
			map_nxt[dest_i].tag = new_tag_i;
			map_nxt[dest_i].rdy = 1'b0; // Producer not done yet.
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			map_q <= map_rst;
		end else begin
			map_q <= map_nxt;
		end
	end

endmodule

/* source/rename_br_top.sv */
// Rename stage with branch checkpoints.
// Dispatch handshake, map table and branch stack.
module rename_br_top (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  disp_valid_i,
	input  rename_pkg::disp_req_t disp_req_i,
	output logic                  disp_ready_o,
	output rename_pkg::disp_rsp_t disp_rsp_o,
	input  br_pkg::br_res_t       resolve_i,
	input  rename_pkg::cdb_t      cdb_i,
	output logic                  rc_valid_o,    // Wrong-path recovery.
	output br_pkg::ckpt_ptr_t     rc_ptr_o,      // Saved head and tail.
	output br_pkg::br_mask_t      squash_mask_o  // Resolving branch bit.
);

	logic                 xfer;     // Handshake completes.
	logic                 wr_en;
	logic                 br_alloc;
	logic                 br_full;
	rename_pkg::map_tbl_t map_cur;
	rename_pkg::map_tbl_t rc_map;
	rename_pkg::map_ent_t src1_ent;
	rename_pkg::map_ent_t src2_ent;
	rename_pkg::prf_tag_t old_tag;
	br_pkg::br_mask_t     br_mask;
	br_pkg::br_mask_t     br_new;

	// Stall during recovery, and a branch stalls when the stack is full.
	assign disp_ready_o = (resolve_i.state != br_pkg::BR_ST_WRONG) &&
	                      !(disp_req_i.is_br && br_full);
	assign xfer     = disp_valid_i && disp_ready_o;
	assign wr_en    = xfer && disp_req_i.has_dest && !disp_req_i.is_br;
	assign br_alloc = xfer && disp_req_i.is_br;

	assign squash_mask_o = (resolve_i.state != br_pkg::BR_ST_NONE) ? resolve_i.tag : '0;

	map_table u_map_table (
		.clk           (clk),
		.rst_i         (rst_i),
		.src1_i        (disp_req_i.src1),
		.src2_i        (disp_req_i.src2),
		.dest_i        (disp_req_i.dest),
		.wr_en_i       (wr_en),
		.new_tag_i     (disp_req_i.new_tag),
		.cdb_i         (cdb_i),
		.restore_i     (rc_valid_o),
		.restore_map_i (rc_map),
		.src1_o        (src1_ent),
		.src2_o        (src2_ent),
		.old_tag_o     (old_tag),
		.map_o         (map_cur)
	);

	branch_stack u_branch_stack (
		.clk        (clk),
		.rst_i      (rst_i),
		.br_alloc_i (br_alloc),
		.resolve_i  (resolve_i),
		.cdb_i      (cdb_i),
		.map_i      (map_cur),
		.ptr_i      (disp_req_i.ptr),
		.br_mask_o  (br_mask),
		.br_new_o   (br_new),
		.full_o     (br_full),
		.rc_valid_o (rc_valid_o),
		.rc_map_o   (rc_map),
		.rc_ptr_o   (rc_ptr_o)
	);

	// Response is valid whenever the request is, no register.
	always_comb begin
		disp_rsp_o.src1    = src1_ent;
		disp_rsp_o.src2    = src2_ent;
		disp_rsp_o.old_tag = old_tag;
		disp_rsp_o.br_mask = br_mask;
		disp_rsp_o.br_new  = br_new;
	end

endmodule

/* verif/rename_br_asserts.sv */
// Concurrent assertions for the rename stage with branch checkpoints.
// Shadow branch mask and saved pointers, allocation, stall and recovery checks.
module rename_br_asserts (
	input logic                  clk,
	input logic                  rst_i,
	input logic                  disp_valid_i,
	input rename_pkg::disp_req_t disp_req_i,
	input logic                  disp_ready_o,
	input rename_pkg::disp_rsp_t disp_rsp_o,
	input br_pkg::br_res_t       resolve_i,
	input logic                  rc_valid_o,
	input br_pkg::ckpt_ptr_t     rc_ptr_o,
	input br_pkg::br_mask_t      squash_mask_o
);

	br_pkg::br_mask_t  sh_mask;  // Live branches.
	br_pkg::br_mask_t  sh_clr;   // After this cycle's correct resolve.
	br_pkg::br_mask_t  sh_free;  // Lowest zero bit of sh_clr.
	br_pkg::ckpt_ptr_t sh_ptr [br_pkg::BR_DEPTH];
	br_pkg::ckpt_ptr_t sh_rc;    // Pointers of the resolving branch.
	logic              br_xfer;
	logic              wrong;

	assign wrong   = (resolve_i.state == br_pkg::BR_ST_WRONG);
	assign br_xfer = disp_valid_i && disp_ready_o && disp_req_i.is_br;

	always_comb begin
		sh_clr = sh_mask;
		if (resolve_i.state == br_pkg::BR_ST_CORRECT) sh_clr = sh_mask & ~resolve_i.tag;
		sh_free = '0;
		for (int i = br_pkg::BR_DEPTH - 1; i >= 0; i--) begin
			if (!sh_clr[i]) sh_free = br_pkg::br_mask_t'(1) << i; // Lowest wins.
		end
		sh_rc = '0;
		for (int i = 0; i < br_pkg::BR_DEPTH; i++) begin
			if (resolve_i.tag[i]) sh_rc = sh_ptr[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			sh_mask <= '0;
		end else if (wrong) begin
			sh_mask <= resolve_i.dep_mask; // Younger branches drop out.
		end else if (br_xfer) begin
			sh_mask <= sh_clr | sh_free;
			for (int i = 0; i < br_pkg::BR_DEPTH; i++) begin
				if (sh_free[i]) sh_ptr[i] <= disp_req_i.ptr;
			end
		end else begin
			sh_mask <= sh_clr;
		end
	end

	a_mask: assert property (@(posedge clk) disable iff (rst_i)
		disp_rsp_o.br_mask == sh_clr) else $error("branch mask differs from shadow");
	a_alloc: assert property (@(posedge clk) disable iff (rst_i)
		br_xfer |-> disp_rsp_o.br_new == sh_free) else $error("branch not given lowest free bit");
	a_full: assert property (@(posedge clk) disable iff (rst_i)
		((&sh_clr) && !wrong) |-> (disp_ready_o == !disp_req_i.is_br))
		else $error("full stack stall wrong");
	a_squash: assert property (@(posedge clk) disable iff (rst_i)
		(resolve_i.state != br_pkg::BR_ST_NONE) |-> squash_mask_o == resolve_i.tag)
		else $error("squash mask is not the resolving tag");
	a_recover: assert property (@(posedge clk) disable iff (rst_i)
		wrong |-> (!disp_ready_o && rc_valid_o && rc_ptr_o == sh_rc))
		else $error("bad recovery outputs");
	a_no_rc: assert property (@(posedge clk) disable iff (rst_i)
		!wrong |-> !rc_valid_o) else $error("recovery without a mispredict");

endmodule

bind rename_br_top rename_br_asserts u_asserts (.*);

/* verif/rename_br_tb.sv */
// Testbench for the rename stage with branch checkpoints.
// Clock, reset, directed and seeded random stimulus, map model and lookup checks.
module rename_br_tb;

	logic                  clk;
	logic                  rst_i;
	logic                  disp_valid_i;
	rename_pkg::disp_req_t disp_req_i;
	logic                  disp_ready_o;
	rename_pkg::disp_rsp_t disp_rsp_o;
	br_pkg::br_res_t       resolve_i;
	rename_pkg::cdb_t      cdb_i;
	logic                  rc_valid_o;
	br_pkg::ckpt_ptr_t     rc_ptr_o;
	br_pkg::br_mask_t      squash_mask_o;

	rename_pkg::map_tbl_t model;                       // Expected live map.
	rename_pkg::map_tbl_t ckpt [br_pkg::BR_DEPTH];     // Expected snapshots.
	br_pkg::br_mask_t     dep [br_pkg::BR_DEPTH];      // Dependency mask per branch.
	br_pkg::br_mask_t     live;                        // Branches in flight.
	int                   idx;

	rename_br_top i_dut (.*);

	always #10 clk = ~clk;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	// Index of the lowest clear bit, the one a new branch takes.
	function automatic int lowest_free(input br_pkg::br_mask_t m);
		int r;
		r = 0;
		for (int i = br_pkg::BR_DEPTH - 1; i >= 0; i--) begin
			if (!m[i]) r = i; // Lower bits win.
		end
		return r;
	endfunction

	// Rename a destination, or take a checkpoint for a branch.
	task automatic dispatch(input rename_pkg::disp_req_t r);
		int n;
		int b;
		n = 0;
		@(posedge clk);
		disp_valid_i <= 1'b1;
		disp_req_i   <= r;
		@(negedge clk);
		while (!disp_ready_o) begin
			n++;
			if (n > 20) begin
				$display("TEST RESULT: FAIL");
				$fatal(1, "dispatch was never accepted");
			end
			@(negedge clk);
		end
		check("src1", disp_rsp_o.src1, model[r.src1]);
		check("src2", disp_rsp_o.src2, model[r.src2]);
		if (r.has_dest) check("old_tag", disp_rsp_o.old_tag, model[r.dest].tag);
		@(posedge clk);
		disp_valid_i <= 1'b0;
		if (r.is_br) begin
			b       = lowest_free(live);
			ckpt[b] = model;
			dep[b]  = live; // Older branches only.
			live[b] = 1'b1;
		end else if (r.has_dest) begin
			model[r.dest].tag = r.new_tag;
			model[r.dest].rdy = 1'b0; // Producer pending.
		end
	endtask

	task automatic broadcast(input rename_pkg::prf_tag_t t);
		@(posedge clk);
		cdb_i <= '{valid: 1'b1, tag: t};
		@(posedge clk);
		cdb_i <= '0;
		for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
			if (model[i].tag == t) model[i].rdy = 1'b1;
			for (int j = 0; j < br_pkg::BR_DEPTH; j++) begin
				if (ckpt[j][i].tag == t) ckpt[j][i].rdy = 1'b1;
			end
		end
	endtask

	task automatic resolve(input br_pkg::br_state_t st, input int b);
		@(posedge clk);
		resolve_i <= '{state: st, tag: br_pkg::br_mask_t'(1) << b, dep_mask: dep[b]};
		@(negedge clk);
		check("squash_mask_o", squash_mask_o, br_pkg::br_mask_t'(1) << b);
		check("rc_valid_o", rc_valid_o, st == br_pkg::BR_ST_WRONG);
		// A correct resolve frees its bit already in this cycle.
		if (st == br_pkg::BR_ST_WRONG) begin
			model = ckpt[b];
			live  = dep[b];
		end else begin
			live &= ~(br_pkg::br_mask_t'(1) << b);
			for (int j = 0; j < br_pkg::BR_DEPTH; j++) dep[j][b] = 1'b0;
		end
		@(posedge clk);
		resolve_i <= '0;
	endtask

	// Lookup of one register with no transfer.
	task automatic peek(input rename_pkg::arch_idx_t a);
		@(posedge clk);
		disp_req_i <= '{src1: a, src2: a, dest: a, default: '0};
		@(negedge clk);
		check("src1", disp_rsp_o.src1, model[a]);
	endtask

	function automatic rename_pkg::disp_req_t make_req(input logic br, input logic [2:0] d,
		input rename_pkg::prf_tag_t t);
		rename_pkg::disp_req_t r;
		r = '{is_br: br, has_dest: !br, dest: d, src1: d, src2: 3'(d + 1), new_tag: t,
			ptr: 8'($urandom), default: '0};
		return r;
	endfunction

	initial begin
		void'($urandom(32'h9ac3));
		clk = 1'b0;
		rst_i = 1'b1;
		disp_valid_i = 1'b0;
		disp_req_i = '0;
		resolve_i = '0;
		cdb_i = '0;
		live = '0;
		for (int i = 0; i < rename_pkg::ARCH_REGS; i++) model[i] = '{tag: 5'(i), rdy: 1'b1};
		for (int j = 0; j < br_pkg::BR_DEPTH; j++) begin
			ckpt[j] = model;
			dep[j] = '0;
		end
		repeat (10) @(posedge clk);
		rst_i <= 1'b0;
		for (int i = 0; i < rename_pkg::ARCH_REGS; i++) peek(3'(i)); // Identity map.
		check("rc_valid_o", rc_valid_o, 0);
		dispatch(make_req(1'b0, 3'd2, 5'd20)); // Rename then complete.
		peek(3'd2);
		broadcast(5'd20);
		peek(3'd2);
		dispatch(make_req(1'b0, 3'd4, 5'd24)); // Still pending at the checkpoint.
		dispatch(make_req(1'b1, 3'd0, 5'd0)); // Checkpoint, then speculate.
		dispatch(make_req(1'b0, 3'd2, 5'd21));
		dispatch(make_req(1'b0, 3'd4, 5'd22));
		broadcast(5'd24);                      // Tag held by the checkpoint.
		dispatch(make_req(1'b1, 3'd0, 5'd0));
		dispatch(make_req(1'b1, 3'd0, 5'd0));
		dispatch(make_req(1'b1, 3'd0, 5'd0)); // Stack now full.
		@(posedge clk);
		disp_req_i <= make_req(1'b1, 3'd0, 5'd0);
		@(negedge clk);
		check("disp_ready_o", disp_ready_o, 0);
		dispatch(make_req(1'b0, 3'd5, 5'd23));
		fork // Branch takes bit 2 in the cycle it is freed.
			resolve(br_pkg::BR_ST_CORRECT, 2);
			dispatch(make_req(1'b1, 3'd0, 5'd0));
		join
		resolve(br_pkg::BR_ST_WRONG, 0);
		for (int i = 0; i < rename_pkg::ARCH_REGS; i++) peek(3'(i));
		for (int k = 0; k < 300; k++) begin
			case ($urandom % 5)
				0, 1: dispatch(make_req(1'b0, 3'($urandom), 5'(8 + $urandom % 24)));
				2: if (!(&live)) dispatch(make_req(1'b1, 3'd0, 5'd0));
				3: if (live != '0) begin
					do idx = $urandom % br_pkg::BR_DEPTH; while (!live[idx]);
					resolve(($urandom % 2) ? br_pkg::BR_ST_WRONG : br_pkg::BR_ST_CORRECT, idx);
				end
				default: broadcast(5'($urandom));
			endcase
		end
		for (int i = 0; i < rename_pkg::ARCH_REGS; i++) peek(3'(i));
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* rename_br_top.f */
source/br_pkg.sv
source/rename_pkg.sv
source/br_mask_ctrl.sv
source/br_stack_ent.sv
source/branch_stack.sv
source/map_table.sv
source/rename_br_top.sv
verif/rename_br_asserts.sv
verif/rename_br_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the rename stage testbench with Verilator.
cd "$(dirname "$0")" &&
verilator --binary --assert -Wall -Wno-fatal --top-module rename_br_tb \
	-f rename_br_top.f -o rename_br_sim &&
./obj_dir/rename_br_sim || exit 1
